// File: kd_tree_pkg.sv
/* KD-tree classifier definitions */

package kd_tree_pkg;

  // Patch geometry
  localparam int DIMS    = 5;             // Coordinates per query patch
  localparam int COORD_W = 11;            // Each coordinate is a signed 11-bit value
  localparam int PATCH_W = DIMS * COORD_W;

  // Tree geometry
  // Three levels of internal nodes give seven nodes and eight leaves
  localparam int DEPTH       = 3;
  localparam int NODE_ADDR_W = 3;         // Heap address, root is node 0

  // Configuration word layout
  localparam int WDATA_W     = 22;
  localparam int DIM_W       = 3;         // Only the low bits of the dimension field are kept
  localparam int CFG_DIM_LSB = 0;         // Dimension field occupies bits 10:0
  localparam int CFG_MED_LSB = COORD_W;   // Median occupies bits 21:11

  localparam int QID_W = 8;

  // Any dimension at or above DIMS reads a zero coordinate
  // A reset node holds this value so every query is sent right
  localparam logic [DIM_W-1:0] DIM_INVALID = 3'd7;

  typedef logic signed [COORD_W-1:0] coord_t;

  // Coordinate k lives at bits 11k+10 down to 11k
  typedef logic [PATCH_W-1:0] patch_t;

  typedef logic [DIM_W-1:0] dim_idx_t;

  typedef logic [NODE_ADDR_W-1:0] node_addr_t;

  typedef logic [WDATA_W-1:0] wdata_t;

  // One bit per level taken so far, the newest decision in the low bit
  // After the last level this is the leaf index
  typedef logic [DEPTH-1:0] path_t;

  typedef logic [QID_W-1:0] qid_t;

endpackage

// File: kd_query_if.sv
/* Query stage between tree levels */

`timescale 1ns/1ps

interface kd_query_if;
  import kd_tree_pkg::*;

  logic   valid;  // A query is present in this cycle
  patch_t patch;  // Query coordinates, never modified along the pipe
  path_t  path;   // Branch history, doubles as the node select of the next level
  qid_t   qid;    // Tag that follows the query to the output

  // The producing side of a stage
  modport source (
    output valid,
    output patch,
    output path,
    output qid
  );

  // The consuming side of a stage
  modport sink (
    input valid,
    input patch,
    input path,
    input qid
  );

endinterface

// File: internal_node.sv
/* KD-tree internal node */

`timescale 1ns/1ps

module internal_node (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wen,         // Write strobe decoded from the node address
  input  kd_tree_pkg::wdata_t wdata,
  input  logic                valid,       // High only when the path selects this node
  input  kd_tree_pkg::patch_t patch_in,
  output logic                valid_left,
  output logic                valid_right
);
  import kd_tree_pkg::*;

  dim_idx_t split_dim;  // Which coordinate this node splits on
  coord_t   median;     // Split threshold
  coord_t   coord;      // Coordinate picked out of the incoming patch
  logic     go_left;

  // Split configuration
  // A new word is seen by queries from the following cycle on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      split_dim <= DIM_INVALID;  // Unconfigured node reads a zero coordinate
      median    <= '0;           // Zero is not below zero so the query goes right
    end else if (wen) begin
      split_dim <= wdata[CFG_DIM_LSB +: DIM_W];
      median    <= wdata[CFG_MED_LSB +: COORD_W];
    end
  end

  // Select the coordinate named by split_dim
  // Dimension codes 5 to 7 match no coordinate and leave the zero default
  always_comb begin
    coord = '0;
    for (int k = 0; k < DIMS; k++) begin
      if (split_dim == dim_idx_t'(k)) begin
        coord = patch_in[k*COORD_W +: COORD_W];
      end
    end
  end

  // Both operands are coord_t so the compare is signed
  // A tie with the median falls through to the right branch
  assign go_left = (coord < median);

  assign valid_left  = valid && go_left;   // Left child takes the query
  assign valid_right = valid && !go_left;  // Right child takes the query

endmodule

// File: tree_level.sv
/* One level of the KD tree */

`timescale 1ns/1ps

module tree_level #(
  parameter int LEVEL = 0  // Depth of this level with the root at level 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_wen,
  input  kd_tree_pkg::node_addr_t cfg_addr,
  input  kd_tree_pkg::wdata_t     cfg_wdata,
  kd_query_if.sink                up,     // Query arriving from the level above
  kd_query_if.source              down    // Registered query for the level below
);
  import kd_tree_pkg::*;

  // Level L holds heap addresses 2^L-1 through 2^(L+1)-2
  localparam int NODES = 1 << LEVEL;
  localparam int BASE  = NODES - 1;

  logic [NODES-1:0] node_wen;    // One write strobe per node
  logic [NODES-1:0] node_valid;  // Query routed to this node
  logic [NODES-1:0] node_left;
  logic [NODES-1:0] node_right;
  logic             any_valid;
  logic             branch_right;
  path_t            next_path;

  for (genvar n = 0; n < NODES; n++) begin : g_node
    // Address decode against the heap position of this node
    assign node_wen[n] = cfg_wen && (cfg_addr == node_addr_t'(BASE + n));

    // The path holds exactly LEVEL decisions with zeros above them,
    // so its value is the index of the node within this level
    assign node_valid[n] = up.valid && (up.path == path_t'(n));

    internal_node u_node (
      .clk         (clk),
      .rst_n       (rst_n),
      .wen         (node_wen[n]),
      .wdata       (cfg_wdata),
      .valid       (node_valid[n]),
      .patch_in    (up.patch),
      .valid_left  (node_left[n]),
      .valid_right (node_right[n])
    );
  end

  // At most one node is selected, so OR reduction gives its decision
  assign any_valid    = |(node_left | node_right);
  assign branch_right = |node_right;

  // Shift the history up and append this level's decision
  // Left is 0 and right is 1
  assign next_path = {up.path[DEPTH-2:0], branch_right};

  // Stage valid register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= any_valid;  // Equals up.valid one cycle later
    end
  end

  // Payload of the stage
  // Patch, path and tag move down one level per clock
  always_ff @(posedge clk) begin
    down.patch <= up.patch;  // Patch passes through untouched
    down.path  <= next_path;
    down.qid   <= up.qid;
  end

endmodule

// File: kd_tree_top.sv
/* KD-tree classifier top */

`timescale 1ns/1ps

module kd_tree_top (
  input  logic                    clk,
  input  logic                    rst_n,

  // Node configuration port
  input  logic                    cfg_wen,
  input  kd_tree_pkg::node_addr_t cfg_addr,
  input  kd_tree_pkg::wdata_t     cfg_wdata,

  // Query in
  input  logic                    in_valid,
  input  kd_tree_pkg::patch_t     in_patch,
  input  kd_tree_pkg::qid_t       in_qid,

  // Classified query out, three cycles after it entered
  output logic                    out_valid,
  output kd_tree_pkg::path_t      out_leaf,
  output kd_tree_pkg::patch_t     out_patch,
  output kd_tree_pkg::qid_t       out_qid
);

  kd_query_if stage0 ();  // Raw input into the root level
  kd_query_if stage1 ();
  kd_query_if stage2 ();
  kd_query_if stage3 ();  // Leaf decided

  assign stage0.valid = in_valid;
  assign stage0.patch = in_patch;
  assign stage0.path  = '0;        // No decisions yet, selects the root
  assign stage0.qid   = in_qid;

  tree_level #(.LEVEL(0)) u_level0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wen   (cfg_wen),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .up        (stage0.sink),
    .down      (stage1.source)
  );

  tree_level #(.LEVEL(1)) u_level1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wen   (cfg_wen),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .up        (stage1.sink),
    .down      (stage2.source)
  );

  tree_level #(.LEVEL(2)) u_level2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wen   (cfg_wen),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .up        (stage2.sink),
    .down      (stage3.source)
  );

  assign out_valid = stage3.valid;
  assign out_leaf  = stage3.path;  // Full branch history is the leaf index
  assign out_patch = stage3.patch;
  assign out_qid   = stage3.qid;

endmodule

// File: kd_tree_checker.sv
/* Top-level timing assertions */

`timescale 1ns/1ps

module kd_tree_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input logic               out_valid,
  input kd_tree_pkg::path_t out_leaf
);

  // Reset is synchronous, so the edge after a reset edge shows a quiet output
  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |=> !out_valid
  ) else $error("out_valid high while reset is held");

  // Three registered levels between the query input and the result
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
      out_valid == $past(in_valid, 3)
  ) else $error("out_valid does not follow in_valid by three cycles");

  // A reported leaf must be a real index
  a_leaf_known: assert property (
    @(posedge clk) disable iff (!rst_n)
      out_valid |-> !$isunknown(out_leaf)
  ) else $error("out_leaf unknown while out_valid is high");

endmodule

// File: tb_kd_tree.sv
/* KD-tree classifier testbench */

`timescale 1ns/1ps

module tb_kd_tree;
  import kd_tree_pkg::*;

  localparam int N_RESET_Q  = 8;            // Queries before any node is written
  localparam int N_RAND_Q   = 200;
  localparam int N_TIE_Q    = 4 * DIMS;     // Four probes per split dimension
  localparam int N_B2B_Q    = 32;
  localparam int N_BURST_Q  = 24;           // Patches replayed around each rewrite
  localparam int N_RECONF_Q = 3 * N_BURST_Q;
  localparam int N_WRITES   = 7 + DIMS + 2;
  localparam int N_QUERIES  = N_RESET_Q + N_RAND_Q + N_TIE_Q + N_B2B_Q + N_RECONF_Q;
  localparam int CLK_NS     = 10;
  localparam int TIMEOUT_NS = (N_QUERIES + N_WRITES) * 10 * CLK_NS + 1000;

  // One outstanding query as the model sees it
  typedef struct packed {
    path_t  leaf;
    patch_t patch;
    qid_t   qid;
    int     cycle;  // Cycle count at the negedge where the result must show
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       cfg_wen;
  node_addr_t cfg_addr;
  wdata_t     cfg_wdata;
  logic       in_valid;
  patch_t     in_patch;
  qid_t       in_qid;
  logic       out_valid;
  path_t      out_leaf;
  patch_t     out_patch;
  qid_t       out_qid;

  int       seed  = 74795;
  int       cycle = 0;          // Rising edges seen so far
  expect_t  exp_q [$];          // Issued queries in order
  expect_t  head;
  dim_idx_t model_dim [7];      // Node configuration mirror, heap order
  coord_t   model_med [7];
  patch_t   burst_patch [N_BURST_Q];
  qid_t     next_qid;

  kd_tree_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wen   (cfg_wen),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .in_valid  (in_valid),
    .in_patch  (in_patch),
    .in_qid    (in_qid),
    .out_valid (out_valid),
    .out_leaf  (out_leaf),
    .out_patch (out_patch),
    .out_qid   (out_qid)
  );

  bind kd_tree_top kd_tree_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_leaf  (out_leaf)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Walk the mirrored tree, left on a signed less-than, right otherwise
  function automatic path_t model_leaf(input patch_t p);
    path_t  path;
    int     node;
    coord_t c;
    path = '0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      node = (1 << lvl) - 1 + int'(path);  // Heap index of the node on this path
      c    = '0;                           // Dimension codes 5 to 7 read zero
      if (int'(model_dim[node]) < DIMS) begin
        c = p[int'(model_dim[node]) * COORD_W +: COORD_W];
      end
      path = {path[DEPTH-2:0], !(c < model_med[node])};
    end
    return path;
  endfunction

  function automatic patch_t rand_patch();
    patch_t p;
    for (int k = 0; k < DIMS; k++) begin
      p[k*COORD_W +: COORD_W] = coord_t'($random(seed));
    end
    return p;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_leaf(input path_t exp, input path_t act);
    if (act !== exp) begin
      $display("FAILED at %0d ns: out_leaf expected %0d, got %0d", $time, exp, act);
      stop_run();
    end
  endtask

  task automatic check_patch(input patch_t exp, input patch_t act);
    if (act !== exp) begin
      $display("FAILED at %0d ns: out_patch expected %h, got %h", $time, exp, act);
      stop_run();
    end
  endtask

  task automatic check_qid(input qid_t exp, input qid_t act);
    if (act !== exp) begin
      $display("FAILED at %0d ns: out_qid expected %0d, got %0d", $time, exp, act);
      stop_run();
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      $display("FAILED at %0d ns: out_valid cycle expected %0d, got %0d", $time, exp, act);
      stop_run();
    end
  endtask

  // Called on a falling edge, returns on the next one
  task automatic write_node(input node_addr_t a, input wdata_t w);
    cfg_wen      = 1'b1;
    cfg_addr     = a;
    cfg_wdata    = w;
    model_dim[a] = w[2:0];    // Upper dimension bits are ignored
    model_med[a] = w[21:11];
    @(negedge clk);
    cfg_wen      = 1'b0;
  endtask

  task automatic send_query(input patch_t p);
    expect_t e;
    e.leaf   = model_leaf(p);
    e.patch  = p;
    e.qid    = next_qid;
    e.cycle  = cycle + DEPTH;  // Captured at the next edge, out after three registers
    in_valid = 1'b1;
    in_patch = p;
    in_qid   = next_qid;
    exp_q.push_back(e);
    next_qid = next_qid + 8'd1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Hold off until every issued query has come out
  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0d ns: a result came out with no query outstanding", $time);
        stop_run();
      end else begin
        head = exp_q.pop_front();
        check_leaf(head.leaf, out_leaf);
        check_patch(head.patch, out_patch);
        check_qid(head.qid, out_qid);
        check_latency(head.cycle, cycle);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired after %0d ns with the run still going", TIMEOUT_NS);
    stop_run();
  end

  initial begin
    patch_t p;
    coord_t tie_med;
    wdata_t tie_word;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg_wen   = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    in_valid  = 1'b0;
    in_patch  = '0;
    in_qid    = '0;
    next_qid  = '0;
    for (int n = 0; n < 7; n++) begin
      model_dim[n] = 3'd7;  // Reset nodes send everything right
      model_med[n] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Unconfigured tree, every query lands in leaf 7
    for (int i = 0; i < N_RESET_Q; i++) send_query(rand_patch());
    drain();

    // Random tree, dimension fields include the invalid codes
    for (int n = 0; n < 7; n++) write_node(node_addr_t'(n), wdata_t'($random(seed)));
    for (int i = 0; i < N_RAND_Q; i++) begin
      send_query(rand_patch());
      if (($random(seed) & 3) == 0) @(negedge clk);  // Occasional bubble
    end
    drain();

    // Root split on each dimension, probing the tie and its neighbours
    for (int d = 0; d < DIMS; d++) begin
      tie_med  = coord_t'($random(seed) % 1000);
      tie_word = {tie_med, 8'($random(seed)), dim_idx_t'(d)};  // Junk above the dim code
      write_node(node_addr_t'(0), tie_word);
      for (int v = 0; v < 4; v++) begin
        p = rand_patch();
        case (v)
          0:       p[d*COORD_W +: COORD_W] = tie_med;  // Equal goes right
          1:       p[d*COORD_W +: COORD_W] = coord_t'(tie_med - 1);
          2:       p[d*COORD_W +: COORD_W] = coord_t'(tie_med + 1);
          default: p[d*COORD_W +: COORD_W] = coord_t'(-($random(seed) & 1023) - 1);
        endcase
        send_query(p);
      end
      drain();
    end

    // Full rate, one query per cycle
    for (int i = 0; i < N_B2B_Q; i++) send_query(rand_patch());
    drain();

    // Same patches replayed, one level 1 node then one level 2 node rewritten
    for (int i = 0; i < N_BURST_Q; i++) burst_patch[i] = rand_patch();
    for (int r = 0; r < 3; r++) begin
      if (r == 1) write_node(node_addr_t'(1 + ($random(seed) & 1)), wdata_t'($random(seed)));
      if (r == 2) write_node(node_addr_t'(3 + ($random(seed) & 3)), wdata_t'($random(seed)));
      for (int i = 0; i < N_BURST_Q; i++) send_query(burst_patch[i]);
      if (r < 2) drain();
    end

    repeat (DEPTH + 5) @(negedge clk);  // Last burst gets time to leave the pipe
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d issued queries never came out", exp_q.size());
      stop_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: list.f
kd_tree_pkg.sv
kd_query_if.sv
internal_node.sv
tree_level.sv
kd_tree_top.sv
kd_tree_checker.sv
tb_kd_tree.sv

// File: Makefile
TOP = tb_kd_tree
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "RESULT: FAIL (run ended early)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
